//--- verification/game_input.txt
# hold start pause skip win died | expected stage_num game_won game_over
# skip 1 pulses for one cycle, skip 2 holds the switch; win and died are one-cycle pulses
6 1 0 0 0 0  0 0 0
6 1 0 0 1 0  1 0 0
6 1 0 0 1 0  2 0 0
8 1 0 1 0 0  3 0 0
8 1 0 2 0 0  4 0 0
8 1 0 2 0 0  4 0 0
6 1 0 0 0 0  4 0 0
# pause with status pulses ignored
8 1 1 0 0 0  4 0 0
6 1 1 0 1 0  4 0 0
6 1 1 0 0 1  4 0 0
6 1 0 0 0 0  4 0 0
# win on the boss stage, then restart
6 1 0 0 1 0  4 1 0
6 1 0 0 1 0  4 1 0
6 0 0 0 0 0  0 0 0
6 1 0 0 0 0  0 0 0
6 1 0 0 1 0  1 0 0
6 1 0 0 0 1  1 0 1
6 1 0 0 1 0  1 0 1
6 0 0 0 0 0  0 0 0
# priorities in RUN
6 1 0 0 0 0  0 0 0
8 1 1 0 0 1  0 0 0
6 1 0 0 0 0  0 0 0
6 1 0 0 1 1  0 0 1
6 0 0 0 0 0  0 0 0
# start off while paused
6 1 0 0 0 0  0 0 0
6 1 0 0 1 0  1 0 0
6 1 1 0 0 0  1 0 0
6 0 1 0 0 0  0 0 0
6 0 0 0 0 0  0 0 0

//--- vlog.f
+incdir+hw
hw/game_state_pkg.sv
hw/game_io_pkg.sv
hw/switch_conditioner.sv
hw/stage_controller.sv
hw/game_controller.sv
hw/game_top.sv
verification/game_props.sv
verification/game_checker.sv
verification/game_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the shooter control testbench with Verilator, run it, judge the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -f vlog.f --top-module game_tb -o game_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/game_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi
if ! grep -q "TB PASSED" "$LOG"; then
	echo "simulation ended without a pass line"
	exit 1
fi

exit 0

//--- verification/game_tb.sv
// testbench for the shooter control top level
// replays switch and status segments from a stimulus file and checks the game
// status at the end of each one, while game_checker follows every cycle

`default_nettype none

`include "game_params.svh"

module game_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import game_io_pkg::*;

	typedef struct packed {
		int                       hold;       // cycles in the segment
		logic                     start_game;
		logic                     pause;
		logic [1:0]               skip;       // 0 low, 1 pulse, 2 held
		logic                     win;
		logic                     died;
		logic [`GAME_STAGE_W-1:0] exp_stage;
		logic                     exp_won;
		logic                     exp_over;
	} segment_t;

	logic          clk;
	logic          resetN;
	switch_cmd_t   switches_raw;
	block_status_t status;
	block_ctrl_t   ctrl;
	game_status_t  result;
	int            checker_errors;
	int            file_errors;
	int            wd_cycles;
	logic          wd_armed;
	segment_t      segments [$];

	game_top u_game_top (
		.clk          (clk),
		.resetN       (resetN),
		.switches_raw (switches_raw),
		.status       (status),
		.ctrl         (ctrl),
		.result       (result)
	);

	game_checker u_game_checker (
		.clk          (clk),
		.resetN       (resetN),
		.switches_raw (switches_raw),
		.status       (status),
		.ctrl         (ctrl),
		.result       (result),
		.errors       (checker_errors)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic bit load_segments();
		int       fd;
		int       f [9];
		string    line;
		segment_t seg;
		fd = $fopen("verification/game_input.txt", "r");
		if (fd == 0) begin
			return 1'b0;
		end
		while ($fgets(line, fd) != 0) begin
			// comment and blank lines scan no fields
			if ($sscanf(line, "%d %d %d %d %d %d %d %d %d", f[0], f[1], f[2], f[3], f[4],
					f[5], f[6], f[7], f[8]) == 9) begin
				seg.hold       = f[0];
				seg.start_game = f[1][0];
				seg.pause      = f[2][0];
				seg.skip       = f[3][1:0];
				seg.win        = f[4][0];
				seg.died       = f[5][0];
				seg.exp_stage  = f[6][`GAME_STAGE_W-1:0];
				seg.exp_won    = f[7][0];
				seg.exp_over   = f[8][0];
				segments.push_back(seg);
			end
		end
		$fclose(fd);
		return segments.size() != 0;
	endfunction

	task automatic check_value(input string name, input int exp_v, input int act_v);
		if (exp_v != act_v) begin
			$display("Fail at %0d ns: %s expected %0d, got %0d", $time, name, exp_v, act_v);
			file_errors++;
		end
	endtask

	task automatic run_segment(input segment_t seg);
		@(posedge clk);
		switches_raw.start_game <= seg.start_game;
		switches_raw.pause      <= seg.pause;
		switches_raw.skip_stage <= (seg.skip != 2'd0);
		for (int i = 1; i < seg.hold; i++) begin
			@(posedge clk);
			if (i == 1 && seg.skip == 2'd1) begin
				switches_raw.skip_stage <= 1'b0;
			end
			// status pulse on the third edge meets the synced switches at the FSM
			if (i == 2) begin
				status.win_stage   <= seg.win;
				status.player_died <= seg.died;
			end
			if (i == 3) begin
				status <= '0;
			end
		end
		@(negedge clk);
		check_value("result.stage_num", int'(seg.exp_stage), int'(result.stage_num));
		check_value("result.game_won", int'(seg.exp_won), int'(result.game_won));
		check_value("result.game_over", int'(seg.exp_over), int'(result.game_over));
	endtask

	task automatic print_summary();
		$display("segment check errors: %0d, checker errors: %0d", file_errors, checker_errors);
	endtask

	initial begin
		int gap;
		resetN       = 1'b0;
		switches_raw = '0;
		status       = '0;
		file_errors  = 0;
		wd_armed     = 1'b0;
		wd_cycles    = 20;
		void'($urandom(6690));
		if (!load_segments()) begin
			$display("could not read any segments from verification/game_input.txt");
			$display("TB FAILED");
			$finish;
		end else begin
			foreach (segments[i]) begin
				wd_cycles += segments[i].hold + 4;
			end
			wd_armed = 1'b1;
			repeat (8) @(posedge clk);
			resetN <= 1'b1;
			foreach (segments[i]) begin
				run_segment(segments[i]);
				gap = $urandom % 4;  // idle gap, inputs held
				repeat (gap) @(posedge clk);
			end
			@(negedge clk);
			print_summary();
			if (file_errors == 0 && checker_errors == 0) begin
				$display("TB PASSED");
			end else begin
				$display("TB FAILED");
			end
			$finish;
		end
	end

	// watchdog, limit comes from the segment lengths
	initial begin
		wait (wd_armed);
		#(wd_cycles * 10);
		$display("timeout: the run did not finish within %0d clock cycles", wd_cycles);
		file_errors++;
		print_summary();
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/game_checker.sv
// cycle model of the shooter control, compared with the DUT on every falling edge
// covers the switch synchronizers, the skip edge, the game FSM and the stage counter

`default_nettype none

`include "game_params.svh"

module game_checker (
	input  logic                       clk,
	input  logic                       resetN,
	input  game_io_pkg::switch_cmd_t   switches_raw,
	input  game_io_pkg::block_status_t status,
	input  game_io_pkg::block_ctrl_t   ctrl,
	input  game_io_pkg::game_status_t  result,
	output int                         errors
);
	timeunit 1ns;
	timeprecision 100ps;

	import game_state_pkg::*;
	import game_io_pkg::*;

	localparam logic [`GAME_STAGE_W-1:0] BOSS_STAGE  = `GAME_STAGE_W'(`GAME_NUM_STAGES - 1);
	localparam logic [`GAME_STAGE_W-1:0] ASTERO_FROM = `GAME_STAGE_W'(`GAME_MONST_STAGES);

	switch_cmd_t              pipe [`GAME_SYNC_DEPTH];
	switch_cmd_t              seen;         // switches as the FSM sees them
	logic                     skip_old;
	logic                     skip_strobe;
	game_state_t              st_m;
	logic [`GAME_STAGE_W-1:0] stage_m;
	block_ctrl_t              exp_ctrl;
	game_status_t             exp_result;
	int                       err_count = 0;

	assign seen   = pipe[`GAME_SYNC_DEPTH-1];
	assign errors = err_count;

	// stages 0..2 monsters, 3 asteroids, 4 boss
	function automatic stage_kind_t kind_of(input logic [`GAME_STAGE_W-1:0] s);
		stage_kind_t k;
		if (s == BOSS_STAGE) begin
			k = BOSS;
		end else if (s >= ASTERO_FROM) begin
			k = ASTERO;
		end else begin
			k = MONST;
		end
		return k;
	endfunction

	function automatic game_state_t step(input game_state_t cur, input logic start,
			input logic pause, input logic died, input logic won, input logic last);
		game_state_t nxt;
		nxt = cur;
		if (!start) begin
			nxt = IDLE;
		end else if (cur == IDLE || cur == STAGE_WON) begin
			nxt = RUN;
		end else if (cur == PAUSE && !pause) begin
			nxt = RUN;
		end else if (cur == RUN) begin
			if (pause) begin
				nxt = PAUSE;
			end else if (died) begin
				nxt = GAME_OVER;
			end else if (won) begin
				nxt = last ? GAME_WON : STAGE_WON;
			end
		end
		return nxt;  // endings hold here
	endfunction

	always @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			for (int i = 0; i < `GAME_SYNC_DEPTH; i++) begin
				pipe[i] <= '0;
			end
			skip_old    <= 1'b0;
			skip_strobe <= 1'b0;
			st_m        <= IDLE;
			stage_m     <= '0;
		end else begin
			pipe[0] <= switches_raw;
			for (int i = 1; i < `GAME_SYNC_DEPTH; i++) begin
				pipe[i] <= pipe[i-1];
			end
			skip_old    <= seen.skip_stage;
			skip_strobe <= seen.skip_stage && !skip_old;
			st_m <= step(st_m, seen.start_game, seen.pause, status.player_died,
				status.win_stage || skip_strobe, stage_m == BOSS_STAGE);
			if (st_m == IDLE) begin
				stage_m <= '0;
			end else if (st_m == STAGE_WON && stage_m != BOSS_STAGE) begin
				stage_m <= stage_m + 1'b1;
			end
		end
	end

	always_comb begin
		exp_ctrl.enable_player = (st_m == RUN);
		exp_ctrl.enable_monst  = (st_m == RUN) && (kind_of(stage_m) == MONST);
		exp_ctrl.enable_boss   = (st_m == RUN) && (kind_of(stage_m) == BOSS);
		exp_ctrl.enable_astero = (st_m == RUN) && (kind_of(stage_m) == ASTERO);
		exp_ctrl.resetN_player = (st_m != IDLE);
		exp_ctrl.resetN_monst  = !(st_m == IDLE || st_m == STAGE_WON);
		exp_result.game_won    = (st_m == GAME_WON);
		exp_result.game_over   = (st_m == GAME_OVER);
		exp_result.stage_num   = stage_m;
	end

	// ctrl bits: player, monst, boss, astero, resetN_player, resetN_monst
	always @(negedge clk) begin
		if (resetN) begin
			if (ctrl !== exp_ctrl) begin
				$display("Fail at %0d ns: ctrl expected %b, got %b", $time, exp_ctrl, ctrl);
				err_count++;
			end
			if (result !== exp_result) begin
				$display("Fail at %0d ns: result expected %b, got %b", $time,
					exp_result, result);
				err_count++;
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/game_props.sv
// concurrent checks on the game FSM outputs
// bound into every game_controller instance by the bind below

`default_nettype none

module game_props (
	input logic                      clk,
	input logic                      resetN,
	input game_state_pkg::game_state_t state,
	input game_io_pkg::block_ctrl_t  ctrl,
	input game_io_pkg::game_status_t result
);
	timeunit 1ns;
	timeprecision 100ps;

	import game_state_pkg::*;

	stage_won_single: assert property (@(posedge clk) disable iff (!resetN)
		(state == STAGE_WON) |=> (state != STAGE_WON))
		else $error("STAGE_WON lasted more than one cycle");

	player_only_in_run: assert property (@(posedge clk) disable iff (!resetN)
		ctrl.enable_player |-> (state == RUN))
		else $error("enable_player high outside RUN");

	one_enemy_block: assert property (@(posedge clk) disable iff (!resetN)
		$onehot0({ctrl.enable_monst, ctrl.enable_boss, ctrl.enable_astero}))
		else $error("more than one enemy block enabled");

	endings_exclusive: assert property (@(posedge clk) disable iff (!resetN)
		!(result.game_won && result.game_over))
		else $error("game_won and game_over high together");

endmodule

bind game_controller game_props u_game_props (
	.clk    (clk),
	.resetN (resetN),
	.state  (state),
	.ctrl   (ctrl),
	.result (result)
);

`default_nettype wire

//--- hw/game_top.sv
// board-level top of the shooter control
// raw switches go through the conditioner into the game FSM
// block status comes in, block control and game status go out

`default_nettype none

module game_top (
	input  logic                       clk,
	input  logic                       resetN,
	input  game_io_pkg::switch_cmd_t   switches_raw,
	input  game_io_pkg::block_status_t status,
	output game_io_pkg::block_ctrl_t   ctrl,
	output game_io_pkg::game_status_t  result
);

	import game_io_pkg::*;

	switch_cmd_t switches;  // synchronized, skip as strobe

	switch_conditioner u_switch_conditioner (
		.clk          (clk),
		.resetN       (resetN),
		.switches_raw (switches_raw),
		.switches     (switches)
	);

	// status lines from the other blocks are already synchronous
	game_controller u_game_controller (
		.clk      (clk),
		.resetN   (resetN),
		.switches (switches),
		.status   (status),
		.ctrl     (ctrl),
		.result   (result)
	);

endmodule

`default_nettype wire

//--- hw/game_controller.sv
// top level game FSM: idle, run, pause, stage won, game over, game won
// drives the enemy and player block enables and resets
// owns the stage counter through stage_controller

`default_nettype none

module game_controller (
	input  logic                       clk,
	input  logic                       resetN,
	input  game_io_pkg::switch_cmd_t   switches,  // conditioned, skip is a strobe
	input  game_io_pkg::block_status_t status,
	output game_io_pkg::block_ctrl_t   ctrl,
	output game_io_pkg::game_status_t  result
);

	import game_state_pkg::*;
	import game_io_pkg::*;

	game_state_t state;
	game_state_t next_state;
	stage_info_t stage;
	logic        stage_advance;
	logic        stage_clear;
	logic        stage_win;   // win report or skip request
	logic        running;

	stage_controller u_stage_controller (
		.clk           (clk),
		.resetN        (resetN),
		.stage_advance (stage_advance),
		.stage_clear   (stage_clear),
		.stage         (stage)
	);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	assign stage_win = status.win_stage | switches.skip_stage;

	always_comb begin
		next_state = state;
		if (!switches.start_game) begin
			next_state = IDLE;  // start switch off wins over everything
		end else begin
			case (state)
				IDLE: next_state = RUN;
				RUN: begin
					if (switches.pause) begin
						next_state = PAUSE;
					end else if (status.player_died) begin
						next_state = GAME_OVER;
					end else if (stage_win) begin
						next_state = stage.last ? GAME_WON : STAGE_WON;
					end
				end
				PAUSE: begin
					if (!switches.pause) begin
						next_state = RUN;
					end
				end
				STAGE_WON: next_state = RUN;  // one cycle only
				GAME_OVER,
				GAME_WON: next_state = state;  // wait for start_game to drop
				default: next_state = IDLE;
			endcase
		end
	end

	assign running       = (state == RUN);
	assign stage_advance = (state == STAGE_WON);
	assign stage_clear   = (state == IDLE);

	// enemy block for the current stage only, and only while running
	always_comb begin
		ctrl.enable_player = running;
		ctrl.enable_monst  = running && (stage.kind == MONST);
		ctrl.enable_boss   = running && (stage.kind == BOSS);
		ctrl.enable_astero = running && (stage.kind == ASTERO);
		ctrl.resetN_player = (state != IDLE);
		ctrl.resetN_monst  = (state != IDLE) && (state != STAGE_WON);  // fresh wave per stage
	end

	always_comb begin
		result.game_won  = (state == GAME_WON);
		result.game_over = (state == GAME_OVER);
		result.stage_num = stage.stage_num;
	end

endmodule

`default_nettype wire

//--- hw/stage_controller.sv
// stage counter for the game FSM
// clears on stage_clear, steps on stage_advance, stops at the last stage
// also reports the stage kind and whether this is the final stage

`default_nettype none

`include "game_params.svh"

module stage_controller (
	input  logic                       clk,
	input  logic                       resetN,
	input  logic                       stage_advance,  // one-cycle strobe
	input  logic                       stage_clear,    // level
	output game_state_pkg::stage_info_t stage
);

	import game_state_pkg::*;

	localparam logic [`GAME_STAGE_W-1:0] LAST_STAGE =
		`GAME_STAGE_W'(`GAME_NUM_STAGES - 1);
	localparam logic [`GAME_STAGE_W-1:0] FIRST_NON_MONST =
		`GAME_STAGE_W'(`GAME_MONST_STAGES);

	logic [`GAME_STAGE_W-1:0] stage_cnt;
	logic                     at_last;
	stage_kind_t              kind;

	assign at_last = (stage_cnt == LAST_STAGE);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			stage_cnt <= '0;
		end else if (stage_clear) begin
			stage_cnt <= '0;
		end else if (stage_advance && !at_last) begin  // saturate at the boss
			stage_cnt <= stage_cnt + 1'b1;
		end
	end

	// stage layout: monsters first, boss at the end, asteroids between
	always_comb begin
		if (stage_cnt < FIRST_NON_MONST) begin
			kind = MONST;
		end else if (at_last) begin
			kind = BOSS;
		end else begin
			kind = ASTERO;
		end
	end

	always_comb begin
		stage.stage_num = stage_cnt;
		stage.kind      = kind;
		stage.last      = at_last;
	end

endmodule

`default_nettype wire

//--- hw/switch_conditioner.sv
// brings the board switches into the clock domain
// start_game and pause come out as levels, skip_stage as a one-cycle strobe

`default_nettype none

`include "game_params.svh"

module switch_conditioner (
	input  logic                     clk,
	input  logic                     resetN,
	input  game_io_pkg::switch_cmd_t switches_raw,
	output game_io_pkg::switch_cmd_t switches
);

	import game_io_pkg::*;

	switch_cmd_t sync_q [`GAME_SYNC_DEPTH];  // sync_q[0] samples the pins
	switch_cmd_t synced;
	logic        skip_prev;   // synced skip, one cycle old
	logic        skip_pulse;

	assign synced = sync_q[`GAME_SYNC_DEPTH-1];

	// synchronizer chain, all three switches side by side
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			for (int i = 0; i < `GAME_SYNC_DEPTH; i++) begin
				sync_q[i] <= '0;
			end
		end else begin
			sync_q[0] <= switches_raw;
			for (int i = 1; i < `GAME_SYNC_DEPTH; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	// rising edge of skip, registered
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			skip_prev  <= 1'b0;
			skip_pulse <= 1'b0;
		end else begin
			skip_prev  <= synced.skip_stage;
			skip_pulse <= synced.skip_stage & ~skip_prev;  // held switch gives one pulse
		end
	end

	always_comb begin
		switches.start_game = synced.start_game;
		switches.pause      = synced.pause;
		switches.skip_stage = skip_pulse;
	end

endmodule

`default_nettype wire

//--- hw/game_io_pkg.sv
// types for signals exchanged with the board and the other game blocks
// switches in, block status in, block control and game status out

`default_nettype none

`include "game_params.svh"

package game_io_pkg;

	// board switches, raw or conditioned
	typedef struct packed {
		logic start_game;  // level
		logic pause;       // level
		logic skip_stage;  // one-cycle strobe once conditioned
	} switch_cmd_t;

	// reports from the player and enemy blocks
	typedef struct packed {
		logic win_stage;
		logic player_died;
	} block_status_t;

	typedef struct packed {
		logic enable_player;
		logic enable_monst;
		logic enable_boss;
		logic enable_astero;
		logic resetN_player;  // active low
		logic resetN_monst;   // active low
	} block_ctrl_t;

	typedef struct packed {
		logic                     game_won;
		logic                     game_over;
		logic [`GAME_STAGE_W-1:0] stage_num;
	} game_status_t;

endpackage

`default_nettype wire

//--- hw/game_state_pkg.sv
// types for the game's internal progress
// game FSM states, stage kinds and the stage info bundle

`default_nettype none

`include "game_params.svh"

package game_state_pkg;

	// game FSM states
	typedef enum logic [2:0] {
		IDLE,       // waiting for start_game
		RUN,
		PAUSE,
		STAGE_WON,  // single cycle, advances the stage
		GAME_OVER,
		GAME_WON
	} game_state_t;

	// which enemy block owns the stage
	typedef enum logic [1:0] {
		MONST,
		ASTERO,
		BOSS
	} stage_kind_t;

	typedef struct packed {
		logic [`GAME_STAGE_W-1:0] stage_num;
		stage_kind_t              kind;
		logic                     last;  // final stage, a win ends the game
	} stage_info_t;

endpackage

`default_nettype wire

//--- hw/game_params.svh
// fixed game content for the arcade shooter control
// stage layout and switch synchronizer depth
// include wherever these macros are needed

`ifndef GAME_PARAMS_SVH
`define GAME_PARAMS_SVH

// total stages: monsters first, then asteroids, boss last
`define GAME_NUM_STAGES 5

// leading monster stages (0..2)
`define GAME_MONST_STAGES 3

// flops per switch before the logic sees it
`define GAME_SYNC_DEPTH 2

// stage number width, enough for GAME_NUM_STAGES
`define GAME_STAGE_W 3

`endif
